// ==== verilog/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

    // Board and memory sizes
    localparam int device_num = 8;

    typedef logic [1:0]  dev_stat_t;     // 0 inactive, 1..3 select 8, 16 or 32 bytes
    typedef logic [7:0]  byte_t;
    typedef logic [63:0] sample_word_t;  // Lane k sits at bits 63-8k down to 56-8k
    typedef logic [31:0] bus_word_t;
    typedef logic [7:0]  sample_addr_t;
    typedef logic [9:0]  tx_addr_t;
    typedef logic [13:0] bus_addr_t;

    localparam int block_words = 64;     // Sample words per data block

    localparam tx_addr_t info_base = 10'h000;
    localparam tx_addr_t data_base = 10'h100;

    // Frame layout
    localparam logic [3:0] btype_info = 4'h1;
    localparam logic [3:0] btype_data = 4'hE;

    localparam byte_t info_len  = 8'd14;
    localparam int    head_len  = 4;
    localparam int    trail_len = 4;

    localparam byte_t info_sync0 = 8'h66;
    localparam byte_t info_sync1 = 8'hBB;
    localparam byte_t data_sync0 = 8'h55;
    localparam byte_t data_sync1 = 8'hAA;

    // Bus address bits 13:12
    localparam logic [1:0] region_regs   = 2'd0;
    localparam logic [1:0] region_sample = 2'd1;
    localparam logic [1:0] region_tx     = 2'd2;

    // Word offsets inside the register region
    localparam logic [11:0] reg_ctrl     = 12'd0;
    localparam logic [11:0] reg_status   = 12'd1;
    localparam logic [11:0] reg_dev_stat = 12'd2;
    localparam logic [11:0] reg_temp_lo  = 12'd3;
    localparam logic [11:0] reg_temp_hi  = 12'd4;
    localparam logic [11:0] reg_trig     = 12'd5;

endpackage

`default_nettype wire

// ==== verilog/dp_ram.sv ====
`default_nettype none

module dp_ram #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 256
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(depth)-1:0] waddr,
    input  wire word_t                    wdata,
    input  wire logic [$clog2(depth)-1:0] raddr,
    output word_t                         rdata
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data shows up the cycle after raddr is presented
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    wr_addr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("RAM write with unknown address");

endmodule

`default_nettype wire

// ==== verilog/frame_builder.sv ====
`default_nettype none

module frame_builder (
    input  wire logic                                              clk,
    input  wire logic                                              rst,
    input  wire logic                                              frame_start,
    input  wire logic [3:0]                                        btype,
    input  wire logic [1:0]                                        data_idx,
    input  wire frame_pkg::dev_stat_t [frame_pkg::device_num-1:0]  dev_stat,
    input  wire frame_pkg::byte_t [frame_pkg::device_num-1:0]      dev_temp,
    input  wire frame_pkg::bus_word_t                              trig_word,
    input  wire frame_pkg::sample_word_t                           sample_rdata,
    output logic                                                   frame_done,
    output logic                                                   tx_we,
    output frame_pkg::tx_addr_t                                    tx_waddr,
    output frame_pkg::byte_t                                       tx_wdata,
    output frame_pkg::sample_addr_t                                sample_raddr
);

    typedef enum logic [8:0] {
        st_idle     = 9'b000000001,
        st_dispatch = 9'b000000010,
        st_info     = 9'b000000100,
        st_head     = 9'b000001000,
        st_dev_chk  = 9'b000010000,
        st_prime    = 9'b000100000,
        st_dev_data = 9'b001000000,
        st_trailer  = 9'b010000000,
        st_done     = 9'b100000000
    } state_t;

    state_t state, state_nxt;

    logic [5:0]                             cnt;      // Byte position inside the current section
    logic [5:0]                             dlen;
    logic [$clog2(frame_pkg::device_num):0] dev;      // One spare bit so overrun is visible
    logic                                   dev_active;
    logic                                   last_dev;
    frame_pkg::byte_t                       act_mask;
    frame_pkg::sample_addr_t                block_base;
    frame_pkg::byte_t                       info_byte;
    frame_pkg::byte_t                       head_byte;
    frame_pkg::byte_t                       data_byte;
    frame_pkg::byte_t                       trail_byte;

    function automatic logic [5:0] dev_len(input frame_pkg::dev_stat_t st);
        return (st == 2'd0) ? 6'd0 : (6'd8 << (st - 2'd1));
    endfunction

    always_comb begin
        for (int k = 0; k < frame_pkg::device_num; k++) begin
            act_mask[k] = (dev_stat[k] != 2'd0);
        end
    end

    assign block_base = frame_pkg::sample_addr_t'(frame_pkg::block_words * data_idx);
    assign dev_active = (dev_stat[dev] != 2'd0);
    assign last_dev   = (dev == frame_pkg::device_num - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (frame_start) state_nxt = st_dispatch;
            st_dispatch: begin
                if (btype == frame_pkg::btype_info) state_nxt = st_info;
                else if (btype == frame_pkg::btype_data) state_nxt = st_head;
                else state_nxt = st_done;  // Unknown type writes nothing
            end
            st_info: if (cnt == frame_pkg::info_len - 1) state_nxt = st_done;
            st_head: if (cnt == frame_pkg::head_len - 1) state_nxt = st_dev_chk;
            st_dev_chk: begin
                if (dev_active) state_nxt = st_prime;
                else if (last_dev) state_nxt = st_trailer;
            end
            st_prime: state_nxt = st_dev_data;
            st_dev_data: begin
                if (cnt == dlen - 6'd1) state_nxt = last_dev ? st_trailer : st_dev_chk;
            end
            st_trailer: if (cnt == frame_pkg::trail_len - 1) state_nxt = st_done;
            st_done: if (!frame_start) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    assign tx_we = (state == st_info) || (state == st_head) ||
                   (state == st_dev_data) || (state == st_trailer);
    assign frame_done = (state == st_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            dev  <= '0;
            dlen <= '0;
        end else begin
            if (state != state_nxt) cnt <= '0;
            else if (tx_we) cnt <= cnt + 6'd1;

            if (state == st_dispatch) dev <= '0;
            else if (state == st_dev_chk && !dev_active && !last_dev) dev <= dev + 1'b1;
            else if (state == st_dev_data && state_nxt == st_dev_chk) dev <= dev + 1'b1;

            if (state == st_dev_chk && dev_active) dlen <= dev_len(dev_stat[dev]);
        end
    end

    // Every device reads again from the start of the selected block
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_raddr <= '0;
            tx_waddr     <= '0;
        end else begin
            if (state == st_dev_chk) sample_raddr <= block_base;
            else if (state == st_prime || state == st_dev_data) sample_raddr <= sample_raddr + 1'b1;

            if (state == st_dispatch) begin
                tx_waddr <= (btype == frame_pkg::btype_data) ? frame_pkg::data_base
                                                             : frame_pkg::info_base;
            end else if (tx_we) begin
                tx_waddr <= tx_waddr + 1'b1;
            end
        end
    end

    always_comb begin
        case (cnt)
            6'd0: info_byte = frame_pkg::info_sync0;
            6'd1: info_byte = frame_pkg::info_sync1;
            6'd2: info_byte = 8'h00;
            6'd3: info_byte = frame_pkg::info_len;
            6'd4: info_byte = {dev_stat[0], dev_stat[1], dev_stat[2], dev_stat[3]};
            6'd5: info_byte = {dev_stat[4], dev_stat[5], dev_stat[6], dev_stat[7]};
            default: info_byte = dev_temp[cnt - 6'd6];
        endcase
    end

    always_comb begin
        case (cnt[1:0])
            2'd0: head_byte = frame_pkg::data_sync0;
            2'd1: head_byte = frame_pkg::data_sync1;
            2'd2: head_byte = act_mask;
            default: head_byte = {6'd0, data_idx};
        endcase
    end

    assign data_byte  = sample_rdata[8 * (frame_pkg::device_num - 1 - dev) +: 8];
    assign trail_byte = trig_word[8 * (3 - cnt[1:0]) +: 8];  // Most significant byte first

    always_comb begin
        if (state == st_info) tx_wdata = info_byte;
        else if (state == st_head) tx_wdata = head_byte;
        else if (state == st_dev_data) tx_wdata = data_byte;
        else tx_wdata = trail_byte;
    end

    no_write_when_quiet: assert property (
        @(posedge clk) disable iff (rst)
        tx_we |-> frame_start
    ) else $error("Transmit write outside of a frame");

    dev_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_prime || state == st_dev_data) |-> (dev <= frame_pkg::device_num - 1)
    ) else $error("Device index past the last device");

endmodule

`default_nettype wire

// ==== verilog/host_bus.sv ====
`default_nettype none

module host_bus (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic                                         cyc,
    input  wire logic                                         stb,
    input  wire logic                                         we,
    input  wire frame_pkg::bus_addr_t                         adr,
    input  wire frame_pkg::bus_word_t                         dat_w,
    input  wire logic [3:0]                                   sel,
    input  wire logic                                         frame_done,
    input  wire frame_pkg::byte_t                             tx_rdata,
    output logic                                              ack,
    output frame_pkg::bus_word_t                              dat_r,
    output logic                                              frame_start,
    output logic [3:0]                                        btype,
    output logic [1:0]                                        data_idx,
    output frame_pkg::dev_stat_t [frame_pkg::device_num-1:0]  dev_stat,
    output frame_pkg::byte_t [frame_pkg::device_num-1:0]      dev_temp,
    output frame_pkg::bus_word_t                              trig_word,
    output logic                                              sample_we,
    output frame_pkg::sample_addr_t                           sample_waddr,
    output frame_pkg::sample_word_t                           sample_wdata,
    output frame_pkg::tx_addr_t                               tx_raddr
);

    logic                 access;     // First cycle of a bus cycle
    logic                 tx_rd;
    logic                 tx_pend;
    logic                 reg_wr;
    logic                 sample_wr;
    logic                 start_req;
    logic                 busy;
    logic                 done_bit;
    logic [1:0]           region;
    logic [11:0]          offset;
    frame_pkg::bus_word_t reg_rdata;
    frame_pkg::bus_word_t wr_word;
    frame_pkg::bus_word_t lo_half;

    function automatic frame_pkg::bus_word_t merge(input frame_pkg::bus_word_t old_w,
                                                   input frame_pkg::bus_word_t new_w,
                                                   input logic [3:0] be);
        frame_pkg::bus_word_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    assign region    = adr[13:12];
    assign offset    = adr[11:0];
    assign access    = cyc && stb && !ack && !tx_pend;
    assign tx_rd     = !we && (region == frame_pkg::region_tx);
    assign reg_wr    = access && we && (region == frame_pkg::region_regs);
    assign sample_wr = access && we && (region == frame_pkg::region_sample);
    assign tx_raddr  = adr[$bits(frame_pkg::tx_addr_t)-1:0];

    always_comb begin
        reg_rdata = '0;
        if (region == frame_pkg::region_regs) begin
            case (offset)
                frame_pkg::reg_ctrl:     reg_rdata = {22'd0, data_idx, 4'd0, btype};
                frame_pkg::reg_status:   reg_rdata = {30'd0, done_bit, busy};
                frame_pkg::reg_dev_stat: reg_rdata = {16'd0, dev_stat};
                frame_pkg::reg_temp_lo:  reg_rdata = dev_temp[3:0];
                frame_pkg::reg_temp_hi:  reg_rdata = dev_temp[7:4];
                frame_pkg::reg_trig:     reg_rdata = trig_word;
                default:                 reg_rdata = '0;
            endcase
        end
    end

    assign wr_word   = merge(reg_rdata, dat_w, sel);  // Byte lanes not selected keep their value
    assign start_req = reg_wr && (offset == frame_pkg::reg_ctrl) && wr_word[31] && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btype     <= '0;
            data_idx  <= '0;
            dev_stat  <= '0;
            dev_temp  <= '0;
            trig_word <= '0;
        end else if (reg_wr) begin
            case (offset)
                frame_pkg::reg_ctrl: begin
                    if (!busy) begin
                        btype    <= wr_word[3:0];
                        data_idx <= wr_word[9:8];
                    end
                end
                frame_pkg::reg_dev_stat: dev_stat      <= wr_word[15:0];
                frame_pkg::reg_temp_lo:  dev_temp[3:0] <= wr_word;
                frame_pkg::reg_temp_hi:  dev_temp[7:4] <= wr_word;
                frame_pkg::reg_trig:     trig_word     <= wr_word;
                default: ;
            endcase
        end
    end

    // Start is held until the builder answers with done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_start <= 1'b0;
            busy        <= 1'b0;
            done_bit    <= 1'b0;
        end else if (start_req) begin
            frame_start <= 1'b1;
            busy        <= 1'b1;
            done_bit    <= 1'b0;
        end else if (frame_start && frame_done) begin
            frame_start <= 1'b0;
            busy        <= 1'b0;
            done_bit    <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack       <= 1'b0;
            tx_pend   <= 1'b0;
            sample_we <= 1'b0;
        end else begin
            ack       <= (access && !tx_rd) || tx_pend;  // Transmit reads wait for the RAM
            tx_pend   <= access && tx_rd;
            sample_we <= sample_wr && adr[0];
        end
    end

    always_ff @(posedge clk) begin
        if (sample_wr && !adr[0]) lo_half <= dat_w;
        if (sample_wr && adr[0]) begin
            sample_waddr <= adr[8:1];
            sample_wdata <= {dat_w, lo_half};
        end
        if (tx_pend) dat_r <= {24'd0, tx_rdata};
        else if (access) dat_r <= reg_rdata;
    end

    single_ack: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    ) else $error("Bus ack held for more than one cycle");

endmodule

`default_nettype wire

// ==== verilog/frame_system.sv ====
`default_nettype none

module frame_system (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cyc,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire frame_pkg::bus_addr_t adr,
    input  wire frame_pkg::bus_word_t dat_w,
    input  wire logic [3:0]           sel,
    output logic                      ack,
    output frame_pkg::bus_word_t      dat_r
);

    logic                                             frame_start;
    logic                                             frame_done;
    logic [3:0]                                       btype;
    logic [1:0]                                       data_idx;
    frame_pkg::dev_stat_t [frame_pkg::device_num-1:0] dev_stat;
    frame_pkg::byte_t [frame_pkg::device_num-1:0]     dev_temp;
    frame_pkg::bus_word_t                             trig_word;

    logic                    sample_we;
    frame_pkg::sample_addr_t sample_waddr;
    frame_pkg::sample_word_t sample_wdata;
    frame_pkg::sample_addr_t sample_raddr;
    frame_pkg::sample_word_t sample_rdata;

    logic                tx_we;
    frame_pkg::tx_addr_t tx_waddr;
    frame_pkg::byte_t    tx_wdata;
    frame_pkg::tx_addr_t tx_raddr;
    frame_pkg::byte_t    tx_rdata;

    host_bus host_bus_i (
        .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .sel,
        .frame_done, .tx_rdata,
        .ack, .dat_r, .frame_start, .btype, .data_idx,
        .dev_stat, .dev_temp, .trig_word,
        .sample_we, .sample_waddr, .sample_wdata, .tx_raddr
    );

    frame_builder frame_builder_i (
        .clk, .rst, .frame_start, .btype, .data_idx,
        .dev_stat, .dev_temp, .trig_word, .sample_rdata,
        .frame_done, .tx_we, .tx_waddr, .tx_wdata, .sample_raddr
    );

    // Host fills it, the builder reads it
    dp_ram #(
        .word_t (frame_pkg::sample_word_t),
        .depth  (2 ** $bits(frame_pkg::sample_addr_t))
    ) sample_ram (
        .clk   (clk),
        .we    (sample_we),
        .waddr (sample_waddr),
        .wdata (sample_wdata),
        .raddr (sample_raddr),
        .rdata (sample_rdata)
    );

    dp_ram #(
        .word_t (frame_pkg::byte_t),
        .depth  (2 ** $bits(frame_pkg::tx_addr_t))
    ) tx_ram (
        .clk   (clk),
        .we    (tx_we),
        .waddr (tx_waddr),
        .wdata (tx_wdata),
        .raddr (tx_raddr),
        .rdata (tx_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/frame_system_tb.sv ====
`default_nettype none

module frame_system_tb;

    localparam int half_writes     = 2 * 256;
    localparam int frame_cycles    = 2600;  // Build, status polls and up to 264 four-cycle reads
    localparam int watchdog_cycles = 2 * (half_writes * 4 + 5 * frame_cycles);

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    frame_pkg::bus_addr_t adr;
    frame_pkg::bus_word_t dat_w;
    logic [3:0]           sel;
    logic                 ack;
    frame_pkg::bus_word_t dat_r;

    frame_pkg::sample_word_t samples [256];
    frame_pkg::dev_stat_t    stat_m [frame_pkg::device_num];
    frame_pkg::byte_t        temp_m [frame_pkg::device_num];
    frame_pkg::bus_word_t    trig_m;
    frame_pkg::byte_t        exp_frame [1024];
    int                      exp_len;
    string                   cmp_name;
    frame_pkg::tx_addr_t     cmp_base;
    event                    frame_ready;
    event                    frame_checked;

    frame_system frame_system_i (
        .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .sel, .ack, .dat_r
    );

    always #20 clk = ~clk;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input frame_pkg::byte_t exp,
                              input frame_pkg::byte_t act);
        if (act !== exp) fail_stop($sformatf("[FAIL] %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input frame_pkg::bus_word_t exp,
                              input frame_pkg::bus_word_t act);
        if (act !== exp) fail_stop($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
    endtask

    function automatic frame_pkg::bus_word_t lcg_next(input frame_pkg::bus_word_t state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic frame_pkg::bus_addr_t reg_addr(input logic [11:0] off);
        return {frame_pkg::region_regs, off};
    endfunction

    function automatic frame_pkg::bus_addr_t tx_addr(input frame_pkg::tx_addr_t a);
        return {frame_pkg::region_tx, 2'b00, a};
    endfunction

    // Bit 0 picks the upper half of the 64-bit entry
    function automatic frame_pkg::bus_addr_t sample_addr(input frame_pkg::sample_addr_t a,
                                                         input logic upper);
        return {frame_pkg::region_sample, 3'b000, a, upper};
    endfunction

    function automatic frame_pkg::bus_word_t pack_stat();
        frame_pkg::bus_word_t w;
        w = '0;
        for (int k = 0; k < frame_pkg::device_num; k++) w[2*k +: 2] = stat_m[k];
        return w;
    endfunction

    function automatic frame_pkg::bus_word_t pack_temp(input int first);
        frame_pkg::bus_word_t w;
        for (int k = 0; k < 4; k++) w[8*k +: 8] = temp_m[first + k];
        return w;
    endfunction

    // Expected frame bytes go to exp_frame, the length is returned
    function automatic int build_expected(input logic [3:0] ftype, input logic [1:0] idx);
        int               n;
        int               len;
        frame_pkg::byte_t mask;
        n = 0;
        if (ftype == frame_pkg::btype_info) begin
            exp_frame[0] = frame_pkg::info_sync0;
            exp_frame[1] = frame_pkg::info_sync1;
            exp_frame[2] = 8'h00;
            exp_frame[3] = frame_pkg::info_len;
            exp_frame[4] = {stat_m[0], stat_m[1], stat_m[2], stat_m[3]};
            exp_frame[5] = {stat_m[4], stat_m[5], stat_m[6], stat_m[7]};
            for (int k = 0; k < frame_pkg::device_num; k++) exp_frame[6 + k] = temp_m[k];
            n = 14;
        end else if (ftype == frame_pkg::btype_data) begin
            for (int k = 0; k < frame_pkg::device_num; k++) mask[k] = (stat_m[k] != 2'd0);
            exp_frame[0] = frame_pkg::data_sync0;
            exp_frame[1] = frame_pkg::data_sync1;
            exp_frame[2] = mask;
            exp_frame[3] = {6'd0, idx};
            n = 4;
            for (int k = 0; k < frame_pkg::device_num; k++) begin
                case (stat_m[k])
                    2'd1: len = 8;
                    2'd2: len = 16;
                    2'd3: len = 32;
                    default: len = 0;
                endcase
                for (int j = 0; j < len; j++) begin
                    exp_frame[n] = samples[frame_pkg::block_words * idx + j][63 - 8*k -: 8];
                    n++;
                end
            end
            for (int b = 3; b >= 0; b--) begin
                exp_frame[n] = trig_m[8*b +: 8];
                n++;
            end
        end
        return n;
    endfunction

    task automatic bus_cycle(input logic write, input frame_pkg::bus_addr_t addr,
                             input frame_pkg::bus_word_t wdata,
                             output frame_pkg::bus_word_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        sel   = 4'hF;
        @(negedge clk);
        while (!ack) begin
            waited++;
            if (waited > 8) fail_stop($sformatf("Bus access to %04h got no ack", addr));
            @(negedge clk);
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic bus_write(input frame_pkg::bus_addr_t addr, input frame_pkg::bus_word_t data);
        frame_pkg::bus_word_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input frame_pkg::bus_addr_t addr, output frame_pkg::bus_word_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic run_frame(input string name, input logic [3:0] ftype, input logic [1:0] idx);
        frame_pkg::bus_word_t st;
        int                   polls;
        bus_write(reg_addr(frame_pkg::reg_ctrl), {1'b1, 21'd0, idx, 4'd0, ftype});
        polls = 0;
        st    = '0;
        while (!st[1]) begin
            if (polls == 100) fail_stop($sformatf("%s: the frame build never finished", name));
            bus_read(reg_addr(frame_pkg::reg_status), st);
            polls++;
        end
        check_word({name, " status"}, 32'h0000_0002, st);  // Done set, busy clear
    endtask

    task automatic check_frame(input string name, input frame_pkg::tx_addr_t base);
        cmp_name = name;
        cmp_base = base;
        -> frame_ready;
        @(frame_checked);
    endtask

    // Reads the transmit RAM back and compares it byte by byte
    initial begin
        frame_pkg::bus_word_t rd;
        forever begin
            @(frame_ready);
            for (int i = 0; i < exp_len; i++) begin
                bus_read(tx_addr(frame_pkg::tx_addr_t'(cmp_base + i)), rd);
                check_byte($sformatf("%s byte %0d", cmp_name, i), exp_frame[i], rd[7:0]);
            end
            -> frame_checked;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_stop("Timeout: the tests did not finish within the time limit");
    end

    initial begin
        frame_pkg::bus_word_t rd;
        frame_pkg::bus_word_t lcg;
        clk   = 1'b0;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = 4'h0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        bus_read(reg_addr(frame_pkg::reg_status), rd);
        check_word("status after reset", 32'h0, rd);
        stat_m = '{2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2};
        for (int k = 0; k < frame_pkg::device_num; k++) temp_m[k] = 8'h18 + 8'(k * 7);
        trig_m = 32'hC3A5_1E07;
        bus_write(reg_addr(frame_pkg::reg_dev_stat), pack_stat());
        bus_write(reg_addr(frame_pkg::reg_temp_lo), pack_temp(0));
        bus_write(reg_addr(frame_pkg::reg_temp_hi), pack_temp(4));
        bus_write(reg_addr(frame_pkg::reg_trig), trig_m);
        bus_read(reg_addr(frame_pkg::reg_dev_stat), rd);
        check_word("dev_stat readback", pack_stat(), rd);
        bus_read(reg_addr(frame_pkg::reg_temp_lo), rd);
        check_word("temp_lo readback", pack_temp(0), rd);
        bus_read(reg_addr(frame_pkg::reg_temp_hi), rd);
        check_word("temp_hi readback", pack_temp(4), rd);
        bus_read(reg_addr(frame_pkg::reg_trig), rd);
        check_word("trigger readback", trig_m, rd);

        // Lower half goes first so the RAM sees the whole word at once
        lcg = 32'd47;
        for (int a = 0; a < 256; a++) begin
            lcg = lcg_next(lcg);
            samples[a][31:0] = lcg;
            lcg = lcg_next(lcg);
            samples[a][63:32] = lcg;
            bus_write(sample_addr(frame_pkg::sample_addr_t'(a), 1'b0), samples[a][31:0]);
            bus_write(sample_addr(frame_pkg::sample_addr_t'(a), 1'b1), samples[a][63:32]);
        end

        exp_len = build_expected(frame_pkg::btype_info, 2'd0);
        run_frame("info frame", frame_pkg::btype_info, 2'd0);
        check_frame("info frame", frame_pkg::info_base);

        exp_len = build_expected(frame_pkg::btype_data, 2'd0);
        run_frame("data all active", frame_pkg::btype_data, 2'd0);
        check_frame("data all active", frame_pkg::data_base);

        stat_m = '{2'd3, 2'd0, 2'd1, 2'd0, 2'd2, 2'd2, 2'd0, 2'd0};
        bus_write(reg_addr(frame_pkg::reg_dev_stat), pack_stat());
        exp_len = build_expected(frame_pkg::btype_data, 2'd0);
        run_frame("data inactive devices", frame_pkg::btype_data, 2'd0);
        check_frame("data inactive devices", frame_pkg::data_base);

        exp_len = build_expected(frame_pkg::btype_data, 2'd2);
        run_frame("data index 2", frame_pkg::btype_data, 2'd2);
        check_frame("data index 2", frame_pkg::data_base);

        // Nothing gets written, so the previous frame must still be there
        run_frame("unknown type", 4'h7, 2'd0);
        check_frame("after unknown type", frame_pkg::data_base);

        // A stray write would start at the info base, which still holds the first info frame
        stat_m = '{2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2};
        exp_len = build_expected(frame_pkg::btype_info, 2'd0);
        check_frame("info after unknown type", frame_pkg::info_base);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== frame_system.f ====
verilog/frame_pkg.sv
verilog/dp_ram.sv
verilog/frame_builder.sv
verilog/host_bus.sv
verilog/frame_system.sv
verif/frame_system_tb.sv
